// ==== Makefile ====
# Verilator build and run for the context controller testbench

VERILATOR ?= verilator
TOP       ?= contextCtrlTb
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST OK
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

# the log decides pass or fail, not the exit status of the pipe
run: compile
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== all.f ====
ctxPkg.sv
cacheCmdIf.sv
threadRequestArbiter.sv
ioPortDecoder.sv
freeObjectCache.sv
contextCtrl.sv
tbClock.sv
contextCtrlTb.sv

// ==== cacheCmdIf.sv ====
`timescale 1ns/1ns

interface cacheCmdIf import ctxPkg::*; #(
	parameter int AddrWidth = 8
) ();

	// command side, owned by the port decoder
	cacheCmd_t              cmd;
	logic [31:0]            length;
	logic [23:0]            selector;
	logic [AddrWidth-1:0]   writeAddr;

	// status and results from the cache
	logic                   busy;
	logic                   found;
	cacheEntry_t            foundEntry;
	logic [AddrWidth-1:0]   foundAddr;
	memSize_t               cachedMem;

	modport decoder (
		output cmd, length, selector, writeAddr,
		input  busy
	);

	modport cache (
		input  cmd, length, selector, writeAddr,
		output busy, found, foundEntry, foundAddr, cachedMem
	);

endinterface

// ==== contextCtrl.sv ====
`timescale 1ns/1ns

module contextCtrl import ctxPkg::*; #(
	parameter int NumThreads     = ctxPkg::NumThreads,
	parameter int CacheAddrWidth = 8
) (
	input  logic                      CLK,
	input  logic                      RESETn,
	input  logic                      cena,
	input  logic                      ioReq,
	input  ioPort_t                   ioPort,
	input  logic [31:0]               ioData,
	input  threadMask_t               allocReq,
	input  threadMask_t               getParReq,
	input  threadMask_t               endMsgReq,
	input  threadMask_t               timerReq,
	output logic                      ioAck,
	output classMask_t                pendingReq,
	output threadIdx_t                threadSel,
	output threadMask_t               coreStart,
	output threadMask_t               coreStop,
	output threadMask_t               coreCont,
	output logic                      ready,
	output memSize_t                  freeMem,
	output memSize_t                  cachedMem,
	output logic                      cacheBusy,
	output logic                      found,
	output logic [31:0]               foundLength,
	output logic [23:0]               foundSel,
	output logic [CacheAddrWidth-1:0] foundAddr
);

	classMask_t  grant;
	threadMask_t allocSel;
	threadMask_t getParSel;
	threadMask_t endMsgSel;
	threadMask_t timerSel;

	cacheCmdIf #(.AddrWidth(CacheAddrWidth)) cacheBus ();

	// --------------------
	// request arbiters, one per class
	// --------------------
	threadRequestArbiter #(.NumThreads(NumThreads)) allocArb (
		.CLK, .RESETn, .req(allocReq), .grant(grant[classAlloc]),
		.pending(pendingReq[classAlloc]), .sel(allocSel)
	);

	threadRequestArbiter #(.NumThreads(NumThreads)) getParArb (
		.CLK, .RESETn, .req(getParReq), .grant(grant[classGetPar]),
		.pending(pendingReq[classGetPar]), .sel(getParSel)
	);

	threadRequestArbiter #(.NumThreads(NumThreads)) endMsgArb (
		.CLK, .RESETn, .req(endMsgReq), .grant(grant[classEndMsg]),
		.pending(pendingReq[classEndMsg]), .sel(endMsgSel)
	);

	threadRequestArbiter #(.NumThreads(NumThreads)) timerArb (
		.CLK, .RESETn, .req(timerReq), .grant(grant[classTimer]),
		.pending(pendingReq[classTimer]), .sel(timerSel)
	);

	ioPortDecoder #(.NumThreads(NumThreads)) portDecoder (
		.CLK, .RESETn, .cena, .ioReq, .ioPort, .ioData,
		.allocSel, .getParSel, .endMsgSel, .timerSel, .timerReq,
		.ioAck, .grant, .threadSel, .coreStart, .coreStop, .coreCont,
		.ready, .freeMem, .cache(cacheBus.decoder)
	);

	freeObjectCache #(.CacheAddrWidth(CacheAddrWidth)) objCache (
		.CLK, .RESETn, .cmd(cacheBus.cache)
	);

	// cache results straight to the ports
	assign cacheBusy = cacheBus.busy;
	assign found = cacheBus.found;
	assign foundLength = cacheBus.foundEntry.length;
	assign foundSel = cacheBus.foundEntry.selector;
	assign foundAddr = cacheBus.foundAddr;
	assign cachedMem = cacheBus.cachedMem;

endmodule

// ==== contextCtrlTb.sv ====
`timescale 1ns/1ns

module contextCtrlTb import ctxPkg::*; ();

	localparam int KWrite = 0;
	localparam int KPulse = 1;
	localparam int KWait  = 2;
	localparam int KCena  = 3;
	localparam int Limit  = 1000;

	typedef struct {
		int          kind;
		ioPort_t     port;
		logic [31:0] data;
		logic        stall;
	} step_t;

	logic        CLK;
	logic        RESETn;
	logic        cena;
	logic        ioReq;
	ioPort_t     ioPort;
	logic [31:0] ioData;
	threadMask_t allocReq;
	threadMask_t getParReq;
	threadMask_t endMsgReq;
	threadMask_t timerReq;
	logic        ioAck;
	classMask_t  pendingReq;
	threadIdx_t  threadSel;
	threadMask_t coreStart;
	threadMask_t coreStop;
	threadMask_t coreCont;
	logic        ready;
	memSize_t    freeMem;
	memSize_t    cachedMem;
	logic        cacheBusy;
	logic        found;
	logic [31:0] foundLength;
	logic [23:0] foundSel;
	logic [7:0]  foundAddr;

	// --------------------
	// reference model state
	// --------------------
	cacheEntry_t mRam [256];
	threadMask_t mFlags [4];
	threadIdx_t  mPtr [4];
	threadIdx_t  mThread;
	memSize_t    mFree;
	memSize_t    expCached;
	logic        mReady;
	logic        expFound;
	logic [31:0] mLength;
	logic [23:0] mSel;
	logic [7:0]  mWaddr;
	logic [7:0]  expAddr;
	cacheEntry_t expEntry;
	step_t       steps[$];
	integer      seed = 81009;

	tbClock clkGen (.CLK, .RESETn);

	contextCtrl #(.NumThreads(4), .CacheAddrWidth(8)) contextCtrl_inst (.*);

	task automatic abortRun(string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic checkIdx(string name, threadIdx_t exp, threadIdx_t act);
		if (act !== exp)
			abortRun($sformatf("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act));
	endtask

	task automatic checkMask(string name, threadMask_t exp, threadMask_t act);
		if (act !== exp)
			abortRun($sformatf("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act));
	endtask

	task automatic checkClass(string name, classMask_t exp, classMask_t act);
		if (act !== exp)
			abortRun($sformatf("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act));
	endtask

	task automatic checkMem(string name, memSize_t exp, memSize_t act);
		if (act !== exp)
			abortRun($sformatf("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act));
	endtask

	task automatic checkEntry(string name, cacheEntry_t exp, cacheEntry_t act);
		if (act !== exp)
			abortRun($sformatf("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act));
	endtask

	task automatic checkAddr(string name, logic [7:0] exp, logic [7:0] act);
		if (act !== exp)
			abortRun($sformatf("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act));
	endtask

	task automatic checkBit(string name, logic exp, logic act);
		if (act !== exp)
			abortRun($sformatf("[ERROR] t=%0t %s expected %b actual %b", $time, name, exp, act));
	endtask

	// one clock, then settle past the edge
	task automatic tick();
		@(posedge CLK);
		#1;
	endtask

	function automatic logic [31:0] mainWord(bit start, bit stop, bit cont, bit rdy,
		int op, int cmd, int thread, bit en);
		logic [31:0] w;
		w = '0;
		w[3] = start;
		w[7:4] = 4'(cmd);
		w[11] = rdy;
		w[13:12] = 2'(op);
		w[16] = stop;
		w[17] = cont;
		w[19:18] = 2'(thread);
		w[21] = en;
		return w;
	endfunction

	function automatic classMask_t pendModel();
		classMask_t p;
		for (int c = 0; c < 4; c++)
			p[c] = |mFlags[c];
		return p;
	endfunction

	// round robin from the thread after the last grant
	task automatic grantModel(int cls);
		logic done;
		int   idx;
		done = 1'b0;
		for (int i = 0; i < 4; i++) begin
			idx = (int'(mPtr[cls]) + i) % 4;
			if (!done && mFlags[cls][idx]) begin
				done = 1'b1;
				mFlags[cls][idx] = 1'b0;
				mPtr[cls] = threadIdx_t'(idx + 1);
				mThread = threadIdx_t'(idx);
			end
		end
	endtask

	task automatic cacheModel(cacheCmd_t cmd);
		int          base;
		logic        hit;
		cacheEntry_t e;
		expFound = 1'b0;
		base = (cmd == cmdFreeSlot || cmd == cmdSearch) ? 128 : 0;
		case (cmd)
			cmdWrite: mRam[mWaddr] = cacheEntry_t'({mSel, mLength});
			cmdClear: for (int a = 0; a < 128; a++) mRam[a] = '0;
			cmdCalc: begin
				expCached = '0;
				for (int a = 128; a < 256; a++)
					expCached = expCached + memSize_t'(mRam[a].length);
			end
			default: begin
				for (int a = 0; a < 128; a++) begin
					e = mRam[base + a];
					case (cmd)
						cmdEmptySearch: hit = e.selector != '0;
						cmdSearch:      hit = mLength >= e.length;
						default:        hit = e.selector == '0;
					endcase
					if (!expFound && hit) begin
						expFound = 1'b1;
						expAddr = 8'(base + a);
						expEntry = e;
					end
				end
			end
		endcase
	endtask

	// pulses go to the thread selected before this write
	task automatic mainModel(logic [31:0] data);
		threadMask_t selBit;
		selBit = threadMask_t'(1) << mThread;
		checkMask("coreStart", data[3] ? selBit : '0, coreStart);
		checkMask("coreStop", data[16] ? selBit : '0, coreStop);
		checkMask("coreCont", data[17] ? selBit : '0, coreCont);
		if (data[21])
			mThread = data[19:18];
		case (data[13:12])
			2'd1: mFree = '0;
			2'd2: mFree = mFree + memSize_t'(mLength);
			2'd3: mFree = mFree - memSize_t'(mLength) - memSize_t'(1);
			default: ;
		endcase
		if (data[11] && cena)
			mReady = 1'b1;
		if (!data[7] && data[6:4] != 3'd0) begin
			checkBit("cacheBusy after ack", 1'b1, cacheBusy);
			cacheModel(cacheCmd_t'(data[6:4]));
		end
	endtask

	// --------------------
	// step handlers
	// --------------------
	task automatic doWrite(step_t s);
		logic prevBusy;
		logic sawBusy;
		int   n;
		ioPort = s.port;
		ioData = s.data;
		ioReq = 1'b1;
		prevBusy = cacheBusy;
		sawBusy = 1'b0;
		n = 0;
		while (!ioAck) begin
			prevBusy = cacheBusy;
			sawBusy = sawBusy | cacheBusy;
			tick();
			n++;
			if (n > Limit)
				abortRun("timeout: ioAck never rose for a port write");
		end
		case (s.port)
			portLength:    mLength = s.data;
			portSelector:  mSel = s.data[23:0];
			portWriteAddr: mWaddr = s.data[7:0];
			portService:   grantModel(int'(s.data[1:0]));
			portMainCtrl:  mainModel(s.data);
			default: ;
		endcase
		if ((s.port == portMainCtrl && !s.data[7] && s.data[6:4] != 3'd0)
			|| s.port == portWriteAddr)
			checkBit("cacheBusy before ack", 1'b0, prevBusy);
		if (s.stall)
			checkBit("stalled on busy", 1'b1, sawBusy);
		checkIdx("threadSel", mThread, threadSel);
		checkMem("freeMem", mFree, freeMem);
		checkBit("ready", mReady, ready);
		ioReq = 1'b0;
		n = 0;
		while (ioAck) begin
			tick();
			n++;
			if (n > Limit)
				abortRun("timeout: ioAck never fell after ioReq dropped");
		end
		checkClass("pendingReq", pendModel(), pendingReq);
		checkMask("coreStart", '0, coreStart);
		checkMask("coreStop", '0, coreStop);
		checkMask("coreCont", '0, coreCont);
	endtask

	task automatic doPulse(int cls, threadMask_t mask);
		case (cls)
			0:       allocReq = mask;
			1:       getParReq = mask;
			2:       endMsgReq = mask;
			default: timerReq = mask;
		endcase
		mFlags[cls] = mFlags[cls] | mask;
		tick();
		allocReq = '0;
		getParReq = '0;
		endMsgReq = '0;
		timerReq = '0;
		checkClass("pendingReq", pendModel(), pendingReq);
		// a timer request also stops its thread
		checkMask("coreStop", (cls == 3) ? mask : '0, coreStop);
	endtask

	task automatic waitIdle();
		int n;
		n = 0;
		while (cacheBusy) begin
			tick();
			n++;
			if (n > Limit)
				abortRun("timeout: cacheBusy never fell");
		end
		checkBit("found", expFound, found);
		if (expFound) begin
			checkAddr("foundAddr", expAddr, foundAddr);
			checkEntry("foundEntry", expEntry, cacheEntry_t'({foundSel, foundLength}));
		end
		checkMem("cachedMem", expCached, cachedMem);
	endtask

	task automatic setCena(logic v);
		cena = v;
		tick();
		if (!cena)
			mReady = 1'b0;
		checkBit("ready", mReady, ready);
	endtask

	// --------------------
	// stimulus table
	// --------------------
	task automatic addStep(int kind, ioPort_t port, logic [31:0] data, logic stall);
		step_t s;
		s.kind = kind;
		s.port = port;
		s.data = data;
		s.stall = stall;
		steps.push_back(s);
	endtask

	task automatic addWrite(ioPort_t port, logic [31:0] data);
		addStep(KWrite, port, data, 1'b0);
	endtask

	task automatic addPulse(logic [1:0] cls, threadMask_t mask);
		addStep(KPulse, portLength, {24'd0, mask, 2'd0, cls}, 1'b0);
	endtask

	task automatic addCmd(int cmd, logic [31:0] len);
		addWrite(portLength, len);
		addWrite(portMainCtrl, mainWord(0, 0, 0, 0, 0, cmd, 0, 0));
		addStep(KWait, portLength, '0, 1'b0);
	endtask

	task automatic addEntry(logic [7:0] addr, logic [23:0] sel, logic [31:0] len);
		addWrite(portSelector, {8'd0, sel});
		addWrite(portWriteAddr, {24'd0, addr});
		addCmd(1, len);
	endtask

	task automatic buildSteps();
		logic [31:0] r;
		// arbitration, wrap of the pointer and an empty class
		addPulse(0, 4'b1011);
		addWrite(portService, 0);
		addWrite(portService, 0);
		addPulse(0, 4'b0001);
		repeat (3) addWrite(portService, 0);
		addPulse(3, 4'b0110);
		addPulse(1, 4'b1000);
		repeat (3) addWrite(portService, 3);
		addWrite(portService, 1);
		addWrite(portService, 2);
		// core pulses and explicit selection
		addWrite(portMainCtrl, mainWord(0, 0, 0, 0, 0, 0, 2, 1));
		addWrite(portMainCtrl, mainWord(1, 0, 0, 0, 0, 0, 0, 0));
		addWrite(portMainCtrl, mainWord(0, 1, 0, 0, 0, 0, 0, 0));
		addWrite(portMainCtrl, mainWord(0, 0, 1, 0, 0, 0, 0, 0));
		addWrite(portMainCtrl, mainWord(1, 1, 1, 0, 0, 0, 1, 1));
		addWrite(portMainCtrl, mainWord(1, 0, 0, 0, 0, 0, 0, 0));
		// free space accumulator and ready
		addWrite(portLength, $random(seed));
		addWrite(portMainCtrl, mainWord(0, 0, 0, 1, 1, 0, 0, 0));
		addWrite(portMainCtrl, mainWord(0, 0, 0, 0, 2, 0, 0, 0));
		addWrite(portLength, $random(seed));
		addWrite(portMainCtrl, mainWord(0, 0, 0, 0, 3, 0, 0, 0));
		addWrite(portMainCtrl, mainWord(0, 0, 0, 0, 3, 0, 0, 0));
		addStep(KCena, portLength, 32'd0, 1'b0);
		addWrite(portMainCtrl, mainWord(0, 0, 0, 1, 2, 0, 0, 0));
		addStep(KCena, portLength, 32'd1, 1'b0);
		addWrite(portMainCtrl, mainWord(0, 0, 0, 1, 0, 0, 0, 0));
		// fill the cache, some free slots upstairs
		addCmd(2, 0);
		for (int a = 128; a < 256; a++) begin
			r = $random(seed);
			addEntry(8'(a), (r[2:0] == 3'd0) ? 24'd0 : r[31:8], $random(seed));
		end
		for (int i = 0; i < 4; i++) begin
			r = $random(seed);
			addEntry({3'd0, r[4:0]}, r[31:8] | 24'd1, $random(seed));
		end
		addCmd(5, $random(seed));
		addCmd(5, 0);
		addCmd(5, 32'hffffffff);
		addCmd(3, 0);
		addCmd(6, 0);
		addCmd(7, 0);
		addCmd(4, 0);
		// search issued while calc still runs
		addWrite(portMainCtrl, mainWord(0, 0, 0, 0, 0, 4, 0, 0));
		addWrite(portLength, $random(seed));
		addStep(KWrite, portMainCtrl, mainWord(0, 0, 0, 0, 0, 5, 0, 0), 1'b1);
		addStep(KWait, portLength, '0, 1'b0);
		addCmd(2, 0);
		addCmd(7, 0);
	endtask

	initial begin
		int n;
		cena = 1'b1;
		ioReq = 1'b0;
		ioPort = portLength;
		ioData = '0;
		allocReq = '0;
		getParReq = '0;
		endMsgReq = '0;
		timerReq = '0;
		for (int a = 0; a < 256; a++)
			mRam[a] = '0;
		for (int c = 0; c < 4; c++) begin
			mFlags[c] = '0;
			mPtr[c] = '0;
		end
		mThread = '0;
		mFree = '0;
		mReady = 1'b0;
		expFound = 1'b0;
		expCached = '0;
		buildSteps();
		n = 0;
		while (RESETn !== 1'b1) begin
			@(posedge CLK);
			n++;
			if (n > Limit)
				abortRun("timeout: reset was never released");
		end
		tick();
		// state right after reset
		checkBit("ioAck", 1'b0, ioAck);
		checkClass("pendingReq", '0, pendingReq);
		checkMask("coreStart", '0, coreStart);
		checkMask("coreStop", '0, coreStop);
		checkMask("coreCont", '0, coreCont);
		checkBit("ready", 1'b0, ready);
		checkBit("cacheBusy", 1'b0, cacheBusy);
		checkBit("found", 1'b0, found);
		checkIdx("threadSel", '0, threadSel);
		checkMem("freeMem", '0, freeMem);
		checkMem("cachedMem", '0, cachedMem);
		foreach (steps[i]) begin
			case (steps[i].kind)
				KWrite:  doWrite(steps[i]);
				KPulse:  doPulse(int'(steps[i].data[1:0]), steps[i].data[7:4]);
				KWait:   waitIdle();
				default: setCena(steps[i].data[0]);
			endcase
		end
		$display("TEST OK");
		$finish;
	end

endmodule

// ==== ctxPkg.sv ====
package ctxPkg;

	// default thread count of the controller
	localparam int NumThreads = 4;

	// --------------------
	// thread and request types
	// --------------------
	typedef logic [1:0] threadIdx_t;
	typedef logic [3:0] threadMask_t;

	typedef enum logic [1:0] {
		classAlloc  = 2'd0,
		classGetPar = 2'd1,
		classEndMsg = 2'd2,
		classTimer  = 2'd3
	} reqClass_t;

	// one pending bit per request class
	typedef logic [3:0] classMask_t;

	// --------------------
	// host write port
	// --------------------
	typedef enum logic [3:0] {
		portMainCtrl  = 4'd3,
		portLength    = 4'd6,
		portSelector  = 4'd7,
		portWriteAddr = 4'd8,
		portService   = 4'd14
	} ioPort_t;

	typedef enum logic [2:0] {
		cmdNone        = 3'd0,
		cmdWrite       = 3'd1,
		cmdClear       = 3'd2,
		cmdFreeSlot    = 3'd3,
		cmdCalc        = 3'd4,
		cmdSearch      = 3'd5,
		cmdEmptyFree   = 3'd6,
		cmdEmptySearch = 3'd7
	} cacheCmd_t;

	typedef enum logic [1:0] {
		memHold  = 2'd0,
		memClear = 2'd1,
		memAdd   = 2'd2,
		memSub   = 2'd3
	} freeMemOp_t;

	// cache entry, selector in the upper bits
	typedef struct packed {
		logic [23:0] selector;
		logic [31:0] length;
	} cacheEntry_t;

	typedef logic [39:0] memSize_t;

	// --------------------
	// main control word fields
	// --------------------
	localparam int CoreStartBit = 3;
	localparam int CacheCmdLsb  = 4;
	localparam int CacheCmdMsb  = 7;
	localparam int ReadyBit     = 11;
	localparam int FreeOpLsb    = 12;
	localparam int FreeOpMsb    = 13;
	localparam int CoreStopBit  = 16;
	localparam int CoreContBit  = 17;
	localparam int ThreadLsb    = 18;
	localparam int ThreadMsb    = 19;
	localparam int ThreadEnBit  = 21;

endpackage

// ==== freeObjectCache.sv ====
`timescale 1ns/1ns

module freeObjectCache import ctxPkg::*; #(
	parameter int CacheAddrWidth = 8
) (
	input logic      CLK,
	input logic      RESETn,
	cacheCmdIf.cache cmd
);

	localparam int Depth = 2 ** CacheAddrWidth;

	typedef logic [CacheAddrWidth-1:0] addr_t;

	cacheEntry_t ram [Depth];
	cacheEntry_t ramRd;
	cacheEntry_t ramQ;
	// entry latched at command start, also the search key
	cacheEntry_t cmdEntry;
	addr_t       wrAddr;
	addr_t       scanAddr;
	addr_t       ramAddr;
	cacheCmd_t   opCur;
	logic        issuing;
	logic        startUpper;

	// tags follow the two read stages
	logic        tagValid0;
	logic        tagValid1;
	cacheCmd_t   tagOp0;
	cacheCmd_t   tagOp1;
	addr_t       tagAddr0;
	addr_t       tagAddr1;

	logic        writeActive;
	logic        ramWe;
	logic        hit;
	logic        match;
	logic        lastEval;

	assign startUpper = cmd.cmd inside {cmdFreeSlot, cmdSearch, cmdCalc};
	assign writeActive = cmd.busy && opCur == cmdWrite;
	assign ramWe = writeActive || (issuing && opCur == cmdClear);
	assign ramAddr = writeActive ? wrAddr : scanAddr;

	// --------------------
	// RAM with registered output
	// --------------------
	always_ff @(posedge CLK) begin
		if (ramWe)
			ram[ramAddr] <= writeActive ? cmdEntry : '0;
		ramRd <= ram[ramAddr];
		ramQ <= ramRd;
	end

	// match test on returning data
	always_comb begin
		case (tagOp1)
			cmdFreeSlot, cmdEmptyFree: hit = ramQ.selector == '0;
			cmdEmptySearch:            hit = ramQ.selector != '0;
			cmdSearch:                 hit = cmdEntry.length >= ramQ.length;
			default:                   hit = 1'b0;
		endcase
	end

	assign match = tagValid1 && hit;
	// last address of the range comes back now
	assign lastEval = tagValid1 && !tagValid0 && !issuing;

	// --------------------
	// scan control
	// --------------------
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			cmd.busy <= 1'b0;
			cmd.found <= 1'b0;
			cmd.cachedMem <= '0;
			opCur <= cmdNone;
			issuing <= 1'b0;
			tagValid0 <= 1'b0;
			tagValid1 <= 1'b0;
		end else begin
			tagValid0 <= issuing;
			tagValid1 <= tagValid0;
			if (cmd.cmd != cmdNone) begin
				opCur <= cmd.cmd;
				cmd.busy <= 1'b1;
				cmd.found <= 1'b0;
				issuing <= cmd.cmd != cmdWrite;
				if (cmd.cmd == cmdCalc)
					cmd.cachedMem <= '0;
			end else if (writeActive) begin
				cmd.busy <= 1'b0;
			end else begin
				if (issuing && &scanAddr[CacheAddrWidth-2:0])
					issuing <= 1'b0;
				if (tagValid1 && tagOp1 == cmdCalc)
					cmd.cachedMem <= cmd.cachedMem + memSize_t'(ramQ.length);
				if (match) begin
					// stop here, reads still in flight are dropped
					cmd.found <= 1'b1;
					cmd.busy <= 1'b0;
					issuing <= 1'b0;
					tagValid0 <= 1'b0;
					tagValid1 <= 1'b0;
				end else if (lastEval) begin
					cmd.busy <= 1'b0;
				end
			end
		end
	end

	// address counter, tags and results
	always_ff @(posedge CLK) begin
		tagOp0 <= opCur;
		tagOp1 <= tagOp0;
		tagAddr0 <= scanAddr;
		tagAddr1 <= tagAddr0;
		if (cmd.cmd != cmdNone) begin
			scanAddr <= {startUpper, {(CacheAddrWidth-1){1'b0}}};
			cmdEntry <= '{selector: cmd.selector, length: cmd.length};
			wrAddr <= cmd.writeAddr;
		end else if (issuing) begin
			scanAddr <= scanAddr + addr_t'(1);
		end
		if (match) begin
			cmd.foundEntry <= ramQ;
			cmd.foundAddr <= tagAddr1;
		end
	end

endmodule

// ==== ioPortDecoder.sv ====
`timescale 1ns/1ns

module ioPortDecoder import ctxPkg::*; #(
	parameter int NumThreads = ctxPkg::NumThreads
) (
	input  logic        CLK,
	input  logic        RESETn,
	input  logic        cena,
	input  logic        ioReq,
	input  ioPort_t     ioPort,
	input  logic [31:0] ioData,
	input  threadMask_t allocSel,
	input  threadMask_t getParSel,
	input  threadMask_t endMsgSel,
	input  threadMask_t timerSel,
	input  threadMask_t timerReq,
	output logic        ioAck,
	output classMask_t  grant,
	output threadIdx_t  threadSel,
	output threadMask_t coreStart,
	output threadMask_t coreStop,
	output threadMask_t coreCont,
	output logic        ready,
	output memSize_t    freeMem,
	cacheCmdIf.decoder  cache
);

	localparam int AddrWidth = $bits(cache.writeAddr);

	logic        reqSeen;
	logic        needIdle;
	logic        writeStb;
	logic        mainWr;
	logic        svcWr;
	cacheCmd_t   cmdField;
	reqClass_t   svcClass;
	threadMask_t classSel;
	threadMask_t selMask;
	freeMemOp_t  memOp;

	function automatic threadIdx_t maskToIdx(threadMask_t mask);
		threadIdx_t idx;
		idx = '0;
		for (int i = 0; i < NumThreads; i++) begin
			if (mask[i])
				idx = threadIdx_t'(i);
		end
		return idx;
	endfunction

	// --------------------
	// handshake and decode
	// --------------------
	// codes 8..15 in the command field do nothing
	assign cmdField = ioData[CacheCmdMsb] ? cmdNone
		: cacheCmd_t'(ioData[CacheCmdMsb-1:CacheCmdLsb]);
	assign needIdle = (ioPort == portMainCtrl && cmdField != cmdNone) || ioPort == portWriteAddr;
	// hold the ack back while the cache is still working
	assign writeStb = reqSeen && !ioAck && !(cache.busy && needIdle);
	assign mainWr = writeStb && ioPort == portMainCtrl;
	assign svcWr = writeStb && ioPort == portService;
	assign svcClass = reqClass_t'(ioData[1:0]);
	assign memOp = freeMemOp_t'(ioData[FreeOpMsb:FreeOpLsb]);
	assign selMask = threadMask_t'(1) << threadSel;
	assign cache.cmd = mainWr ? cmdField : cmdNone;

	always_comb begin
		grant = '0;
		if (svcWr)
			grant[svcClass] = 1'b1;
		case (svcClass)
			classAlloc:  classSel = allocSel;
			classGetPar: classSel = getParSel;
			classEndMsg: classSel = endMsgSel;
			default:     classSel = timerSel;
		endcase
	end

	// --------------------
	// control registers
	// --------------------
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			reqSeen <= 1'b0;
			ioAck <= 1'b0;
			threadSel <= '0;
			coreStart <= '0;
			coreStop <= '0;
			coreCont <= '0;
			ready <= 1'b0;
			freeMem <= '0;
		end else begin
			reqSeen <= ioReq;
			if (writeStb)
				ioAck <= 1'b1;
			else if (!reqSeen)
				ioAck <= 1'b0;

			// pulses go to the thread selected before this write
			coreStart <= (mainWr && ioData[CoreStartBit]) ? selMask : '0;
			coreStop <= ((mainWr && ioData[CoreStopBit]) ? selMask : '0) | timerReq;
			coreCont <= (mainWr && ioData[CoreContBit]) ? selMask : '0;
			ready <= (ready | (mainWr & ioData[ReadyBit])) & cena;

			if (mainWr && ioData[ThreadEnBit])
				threadSel <= ioData[ThreadMsb:ThreadLsb];
			else if (svcWr && |classSel)
				threadSel <= maskToIdx(classSel);

			// free space accumulator
			if (mainWr) begin
				case (memOp)
					memClear: freeMem <= '0;
					memAdd:   freeMem <= freeMem + memSize_t'(cache.length);
					memSub:   freeMem <= freeMem - memSize_t'(cache.length) - memSize_t'(1);
					default:  freeMem <= freeMem;
				endcase
			end
		end
	end

	// operand registers for the cache
	always_ff @(posedge CLK) begin
		if (writeStb) begin
			case (ioPort)
				portLength:    cache.length <= ioData;
				portSelector:  cache.selector <= ioData[23:0];
				portWriteAddr: cache.writeAddr <= ioData[AddrWidth-1:0];
				default: ;
			endcase
		end
	end

endmodule

// ==== tbClock.sv ====
`timescale 1ns/1ns

module tbClock #(
	parameter int HalfPeriod  = 2,
	parameter int ResetCycles = 3
) (
	output logic CLK,
	output logic RESETn
);

	initial begin
		CLK = 1'b0;
		forever #HalfPeriod CLK = ~CLK;
	end

	// reset low for the first few rising edges
	initial begin
		RESETn = 1'b0;
		repeat (ResetCycles) @(posedge CLK);
		#1 RESETn = 1'b1;
	end

endmodule

// ==== threadRequestArbiter.sv ====
`timescale 1ns/1ns

module threadRequestArbiter import ctxPkg::*; #(
	parameter int NumThreads = ctxPkg::NumThreads
) (
	input  logic        CLK,
	input  logic        RESETn,
	input  threadMask_t req,
	input  logic        grant,
	output logic        pending,
	output threadMask_t sel
);

	// sticky request flag per thread
	threadMask_t flags;
	// where the next search starts, one past the last grant
	threadIdx_t  startPtr;
	threadIdx_t  selIdx;

	// first pending thread at or after startPtr
	always_comb begin
		int idx;
		sel = '0;
		selIdx = startPtr;
		for (int i = NumThreads - 1; i >= 0; i--) begin
			idx = (int'(startPtr) + i) % NumThreads;
			if (flags[idx]) begin
				sel = '0;
				sel[idx] = 1'b1;
				selIdx = threadIdx_t'(idx);
			end
		end
	end

	assign pending = |flags;

	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			flags <= '0;
			startPtr <= '0;
		end else begin
			// a fresh request survives a grant in the same cycle
			flags <= (flags & ~(grant ? sel : '0)) | req;
			if (grant && |sel)
				startPtr <= threadIdx_t'((int'(selIdx) + 1) % NumThreads);
		end
	end

endmodule
